// ==== verilog/tdu_pkg.sv ====
// Shared TDU types and TDATA1 layout; MCONTROL only, no ICOUNT, no chaining, 32-bit CSR word
package tdu_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------
    // CSR word and monitored address width
    localparam int unsigned TDU_DATA_W = 32;
    // TSELECT width, room for up to 15 triggers
    localparam int unsigned TDU_TSEL_W = 4;

    // ------------------------------------------------
    // TDATA1 field positions (MCONTROL layout)
    // ------------------------------------------------
    localparam int unsigned TDU_TDATA1_TYPE_HI          = 31;
    localparam int unsigned TDU_TDATA1_TYPE_LO          = 28;
    localparam int unsigned TDU_TDATA1_DMODE            = 27;
    localparam int unsigned TDU_MCONTROL_MASKMAX_HI     = 26;
    localparam int unsigned TDU_MCONTROL_MASKMAX_LO     = 21;
    localparam int unsigned TDU_MCONTROL_HIT            = 20;
    localparam int unsigned TDU_MCONTROL_SELECT         = 19;
    localparam int unsigned TDU_MCONTROL_TIMING         = 18;
    localparam int unsigned TDU_MCONTROL_ACTION_HI      = 17;
    localparam int unsigned TDU_MCONTROL_ACTION_LO      = 12;
    localparam int unsigned TDU_MCONTROL_CHAIN          = 11;
    localparam int unsigned TDU_MCONTROL_MATCH_HI       = 10;
    localparam int unsigned TDU_MCONTROL_MATCH_LO       = 7;
    localparam int unsigned TDU_MCONTROL_M              = 6;
    // Bit 5 reserved, reads zero
    localparam int unsigned TDU_MCONTROL_S              = 4;
    localparam int unsigned TDU_MCONTROL_U              = 3;
    localparam int unsigned TDU_MCONTROL_EXECUTE        = 2;
    localparam int unsigned TDU_MCONTROL_STORE          = 1;
    localparam int unsigned TDU_MCONTROL_LOAD           = 0;

    // ------------------------------------------------
    // Fixed field values
    // ------------------------------------------------
    localparam logic [3:0] TDU_MCONTROL_TYPE_VAL    = 4'd2;
    localparam logic [5:0] TDU_MCONTROL_MASKMAX_VAL = 6'd0;
    localparam logic       TDU_MCONTROL_SELECT_VAL  = 1'b0;
    localparam logic       TDU_MCONTROL_TIMING_VAL  = 1'b0;
    localparam logic       TDU_MCONTROL_CHAIN_VAL   = 1'b0;
    localparam logic [3:0] TDU_MCONTROL_MATCH_VAL   = 4'd0;
    localparam logic       TDU_MCONTROL_S_VAL       = 1'b0;
    localparam logic       TDU_MCONTROL_U_VAL       = 1'b0;
    // TINFO bit advertising type 2 support
    localparam int unsigned TDU_TINFO_MCONTROL_BIT  = 2;

    // ------------------------------------------------
    // CSR port encodings
    // ------------------------------------------------
    typedef enum logic [1:0] {
        CSR_CMD_NONE  = 2'd0,
        CSR_CMD_WRITE = 2'd1,
        CSR_CMD_SET   = 2'd2,
        CSR_CMD_CLEAR = 2'd3
    } tdu_csr_cmd_e;

    // Register offset within the trigger CSR block
    typedef enum logic [1:0] {
        CSR_ADDR_TSELECT = 2'd0,
        CSR_ADDR_TDATA1  = 2'd1,
        CSR_ADDR_TDATA2  = 2'd2,
        CSR_ADDR_TINFO   = 2'd3
    } tdu_csr_addr_e;

    // ------------------------------------------------
    // Bundles
    // ------------------------------------------------
    typedef struct packed {
        logic                  req;
        tdu_csr_cmd_e          cmd;
        tdu_csr_addr_e         addr;
        logic [TDU_DATA_W-1:0] wdata;
    } tdu_csr_req_t;

    // Response is combinational with req
    typedef struct packed {
        logic [TDU_DATA_W-1:0] rdata;
        logic                  ok;
    } tdu_csr_rsp_t;

    // Instruction fetch monitor, one-cycle strobe
    typedef struct packed {
        logic                  vd;
        logic [TDU_DATA_W-1:0] addr;
    } tdu_imon_t;

    // Load/store address monitor
    typedef struct packed {
        logic                  vd;
        logic                  load;
        logic                  store;
        logic [TDU_DATA_W-1:0] addr;
    } tdu_dmon_t;

    // Stored MCONTROL state of one trigger, action kept as one bit
    typedef struct packed {
        logic dmode;
        logic m;
        logic exec;
        logic load;
        logic store;
        logic action;
        logic hit;
    } tdu_mcontrol_t;

endpackage

// ==== verilog/tdu_csr_access.sv ====
// Trigger CSR front end; MTRIG_NUM must be 1..15, response is combinational, writes land next edge
`timescale 1ns/1ps

module tdu_csr_access #(
    parameter int unsigned MTRIG_NUM = 2
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  tdu_pkg::tdu_csr_req_t                              csr_req_i,
    // Per-trigger state, trigger 0 in the low slice
    input  logic [MTRIG_NUM*$bits(tdu_pkg::tdu_mcontrol_t)-1:0] cfg_i,
    input  logic [MTRIG_NUM*tdu_pkg::TDU_DATA_W-1:0]            tdata2_i,
    output tdu_pkg::tdu_csr_rsp_t                              csr_rsp_o,
    output logic [MTRIG_NUM-1:0]                               tdata1_we_o,
    output logic [MTRIG_NUM-1:0]                               tdata2_we_o,
    output logic [tdu_pkg::TDU_DATA_W-1:0]                     wr_data_o
);

    import tdu_pkg::*;

    localparam int unsigned CFG_W = $bits(tdu_mcontrol_t);

    // TSELECT state
    logic [TDU_TSEL_W-1:0] tselect_q;
    logic                  tselect_we;
    // Selected trigger view
    tdu_mcontrol_t         sel_cfg;
    logic [TDU_DATA_W-1:0] sel_tdata2;
    logic [TDU_DATA_W-1:0] tdata1_rd;
    // Read word and write qualifiers
    logic [TDU_DATA_W-1:0] rdata;
    logic                  wr_req;
    logic                  wr_en;

    // ------------------------------------------------
    // Trigger selection
    // ------------------------------------------------
    // TSELECT only ever holds an existing trigger index
    always_comb begin
        sel_cfg    = '0;
        sel_tdata2 = '0;
        for (int i = 0; i < MTRIG_NUM; i++) begin
            if (tselect_q == TDU_TSEL_W'(i)) begin
                sel_cfg    = cfg_i[i*CFG_W +: CFG_W];
                sel_tdata2 = tdata2_i[i*TDU_DATA_W +: TDU_DATA_W];
            end
        end
    end

    // TDATA1 image: stored bits plus constant fields
    always_comb begin
        tdata1_rd = '0;
        tdata1_rd[TDU_TDATA1_TYPE_HI:TDU_TDATA1_TYPE_LO]           = TDU_MCONTROL_TYPE_VAL;
        tdata1_rd[TDU_TDATA1_DMODE]                                = sel_cfg.dmode;
        tdata1_rd[TDU_MCONTROL_MASKMAX_HI:TDU_MCONTROL_MASKMAX_LO] = TDU_MCONTROL_MASKMAX_VAL;
        tdata1_rd[TDU_MCONTROL_HIT]                                = sel_cfg.hit;
        tdata1_rd[TDU_MCONTROL_SELECT]                             = TDU_MCONTROL_SELECT_VAL;
        tdata1_rd[TDU_MCONTROL_TIMING]                             = TDU_MCONTROL_TIMING_VAL;
        // Action reads back as 0 or 1 only
        tdata1_rd[TDU_MCONTROL_ACTION_LO]                          = sel_cfg.action;
        tdata1_rd[TDU_MCONTROL_CHAIN]                              = TDU_MCONTROL_CHAIN_VAL;
        tdata1_rd[TDU_MCONTROL_MATCH_HI:TDU_MCONTROL_MATCH_LO]     = TDU_MCONTROL_MATCH_VAL;
        tdata1_rd[TDU_MCONTROL_M]                                  = sel_cfg.m;
        tdata1_rd[TDU_MCONTROL_S]                                  = TDU_MCONTROL_S_VAL;
        tdata1_rd[TDU_MCONTROL_U]                                  = TDU_MCONTROL_U_VAL;
        tdata1_rd[TDU_MCONTROL_EXECUTE]                            = sel_cfg.exec;
        tdata1_rd[TDU_MCONTROL_STORE]                              = sel_cfg.store;
        tdata1_rd[TDU_MCONTROL_LOAD]                               = sel_cfg.load;
    end

    // ------------------------------------------------
    // Read path
    // ------------------------------------------------
    always_comb begin
        rdata = '0;
        if (csr_req_i.req) begin
            case (csr_req_i.addr)
                CSR_ADDR_TSELECT: begin
                    rdata = TDU_DATA_W'(tselect_q);
                end
                CSR_ADDR_TDATA1: begin
                    rdata = tdata1_rd;
                end
                CSR_ADDR_TDATA2: begin
                    rdata = sel_tdata2;
                end
                CSR_ADDR_TINFO: begin
                    rdata[TDU_TINFO_MCONTROL_BIT] = 1'b1;
                end
                default: begin
                    rdata = '0;
                end
            endcase
        end
    end

    assign csr_rsp_o.rdata = rdata;
    assign csr_rsp_o.ok    = csr_req_i.req;

    // ------------------------------------------------
    // Write merge
    // ------------------------------------------------
    // SET/CLEAR with an empty mask is a pure read
    always_comb begin
        wr_req    = 1'b0;
        wr_data_o = csr_req_i.wdata;
        case (csr_req_i.cmd)
            CSR_CMD_WRITE: begin
                wr_req = 1'b1;
            end
            CSR_CMD_SET: begin
                wr_req    = |csr_req_i.wdata;
                wr_data_o = rdata | csr_req_i.wdata;
            end
            CSR_CMD_CLEAR: begin
                wr_req    = |csr_req_i.wdata;
                wr_data_o = rdata & ~csr_req_i.wdata;
            end
            default: begin
                wr_req = 1'b0;
            end
        endcase
    end

    assign wr_en = csr_req_i.req & wr_req;

    // One-hot enables toward the selected trigger
    always_comb begin
        tdata1_we_o = '0;
        tdata2_we_o = '0;
        for (int i = 0; i < MTRIG_NUM; i++) begin
            if (wr_en && tselect_q == TDU_TSEL_W'(i)) begin
                tdata1_we_o[i] = (csr_req_i.addr == CSR_ADDR_TDATA1);
                tdata2_we_o[i] = (csr_req_i.addr == CSR_ADDR_TDATA2);
            end
        end
    end

    // ------------------------------------------------
    // TSELECT register
    // ------------------------------------------------
    // Whole word must name an existing trigger
    assign tselect_we = wr_en & (csr_req_i.addr == CSR_ADDR_TSELECT)
                      & ~|wr_data_o[TDU_DATA_W-1:TDU_TSEL_W]
                      & (wr_data_o[TDU_TSEL_W-1:0] < TDU_TSEL_W'(MTRIG_NUM));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tselect_q <= '0;
        end else if (tselect_we) begin
            tselect_q <= wr_data_o[TDU_TSEL_W-1:0];
        end
    end

endmodule

// ==== verilog/tdu_mcontrol_trig.sv ====
// One address-match trigger; exact compare only, M mode only, TDATA2 holds no reset value
`timescale 1ns/1ps

module tdu_mcontrol_trig (
    input  logic                          clk,
    input  logic                          rst_n,
    // Core is halted in debug mode
    input  logic                          dbg_mode_i,
    // CSR side
    input  logic                          tdata1_we_i,
    input  logic                          tdata2_we_i,
    input  logic [tdu_pkg::TDU_DATA_W-1:0] wr_data_i,
    // Monitored streams
    input  tdu_pkg::tdu_imon_t            imon_i,
    input  tdu_pkg::tdu_dmon_t            dmon_i,
    // This trigger's instruction retires
    input  logic                          retire_i,
    // State and matches
    output tdu_pkg::tdu_mcontrol_t        cfg_o,
    output logic [tdu_pkg::TDU_DATA_W-1:0] tdata2_o,
    output logic                          exec_match_o,
    output logic                          ldst_match_o
);

    import tdu_pkg::*;

    // Stored MCONTROL bits
    tdu_mcontrol_t         cfg_q;
    tdu_mcontrol_t         cfg_d;
    // Match address
    logic [TDU_DATA_W-1:0] tdata2_q;
    // Writes after dmode lock check
    logic                  wr_allowed;
    logic                  tdata1_upd;
    logic                  tdata2_upd;
    // Trigger armed in current mode
    logic                  active;
    logic                  ld_hit;
    logic                  st_hit;

    // ------------------------------------------------
    // Write lock
    // ------------------------------------------------
    // Debug-owned trigger only changes from debug mode
    assign wr_allowed = ~cfg_q.dmode | dbg_mode_i;
    assign tdata1_upd = tdata1_we_i & wr_allowed;
    assign tdata2_upd = tdata2_we_i & wr_allowed;

    // ------------------------------------------------
    // MCONTROL next state
    // ------------------------------------------------
    always_comb begin
        cfg_d = cfg_q;
        if (tdata1_upd) begin
            cfg_d.dmode  = wr_data_i[TDU_TDATA1_DMODE];
            cfg_d.m      = wr_data_i[TDU_MCONTROL_M];
            cfg_d.exec   = wr_data_i[TDU_MCONTROL_EXECUTE];
            cfg_d.load   = wr_data_i[TDU_MCONTROL_LOAD];
            cfg_d.store  = wr_data_i[TDU_MCONTROL_STORE];
            // Only value 1 selects debug entry, anything else is a breakpoint
            cfg_d.action = (wr_data_i[TDU_MCONTROL_ACTION_HI:TDU_MCONTROL_ACTION_LO] == 6'd1);
            // CSR write overrides a same-cycle retire
            cfg_d.hit    = wr_data_i[TDU_MCONTROL_HIT];
        end else if (retire_i) begin
            // Sticky until software clears it
            cfg_d.hit = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else begin
            cfg_q <= cfg_d;
        end
    end

    // ------------------------------------------------
    // TDATA2
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (tdata2_upd) begin
            tdata2_q <= wr_data_i;
        end
    end

    assign cfg_o    = cfg_q;
    assign tdata2_o = tdata2_q;

    // ------------------------------------------------
    // Address compare
    // ------------------------------------------------
    // Silent while halted or when M mode is off
    assign active = ~dbg_mode_i & cfg_q.m;

    // Instruction breakpoint
    assign exec_match_o = active
                        & cfg_q.exec
                        & imon_i.vd
                        & (imon_i.addr == tdata2_q);

    // Watchpoint, per-direction enables
    assign ld_hit = cfg_q.load & dmon_i.load;
    assign st_hit = cfg_q.store & dmon_i.store;

    assign ldst_match_o = active
                        & dmon_i.vd
                        & (ld_hit | st_hit)
                        & (dmon_i.addr == tdata2_q);

endmodule

// ==== verilog/tdu_trigger_debug.sv ====
// Trigger debug unit top; MTRIG_NUM 1..15, matches and requests are combinational from monitors
`timescale 1ns/1ps

module tdu_trigger_debug #(
    parameter int unsigned MTRIG_NUM = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dbg_mode_i,
    // CSR port
    input  tdu_pkg::tdu_csr_req_t csr_req_i,
    output tdu_pkg::tdu_csr_rsp_t csr_rsp_o,
    // Execute stage
    input  tdu_pkg::tdu_imon_t    imon_i,
    output logic [MTRIG_NUM-1:0]  ibrk_match_o,
    output logic                  ibrk_exc_req_o,
    input  logic [MTRIG_NUM-1:0]  bp_retire_i,
    // Load/store unit
    input  tdu_pkg::tdu_dmon_t    dmon_i,
    output logic [MTRIG_NUM-1:0]  dbrk_match_o,
    output logic                  dbrk_exc_req_o,
    // Halt controller
    output logic                  dmode_req_o
);

    import tdu_pkg::*;

    localparam int unsigned CFG_W = $bits(tdu_mcontrol_t);

    // Flat per-trigger state toward the CSR block
    logic [MTRIG_NUM*CFG_W-1:0]      cfg;
    logic [MTRIG_NUM*TDU_DATA_W-1:0] tdata2;
    // Write strobes and merged data
    logic [MTRIG_NUM-1:0]            tdata1_we;
    logic [MTRIG_NUM-1:0]            tdata2_we;
    logic [TDU_DATA_W-1:0]           wr_data;
    // Action bits, one per trigger
    logic [MTRIG_NUM-1:0]            action_vec;

    // ------------------------------------------------
    // CSR access
    // ------------------------------------------------
    tdu_csr_access #(
        .MTRIG_NUM (MTRIG_NUM)
    ) i_tdu_csr_access (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req_i   (csr_req_i),
        .cfg_i       (cfg),
        .tdata2_i    (tdata2),
        .csr_rsp_o   (csr_rsp_o),
        .tdata1_we_o (tdata1_we),
        .tdata2_we_o (tdata2_we),
        .wr_data_o   (wr_data)
    );

    // ------------------------------------------------
    // Trigger array
    // ------------------------------------------------
    for (genvar i = 0; i < MTRIG_NUM; i++) begin : g_trig
        tdu_mcontrol_t trig_cfg;

        tdu_mcontrol_trig i_tdu_mcontrol_trig (
            .clk          (clk),
            .rst_n        (rst_n),
            .dbg_mode_i   (dbg_mode_i),
            .tdata1_we_i  (tdata1_we[i]),
            .tdata2_we_i  (tdata2_we[i]),
            .wr_data_i    (wr_data),
            .imon_i       (imon_i),
            .dmon_i       (dmon_i),
            .retire_i     (bp_retire_i[i]),
            .cfg_o        (trig_cfg),
            .tdata2_o     (tdata2[i*TDU_DATA_W +: TDU_DATA_W]),
            .exec_match_o (ibrk_match_o[i]),
            .ldst_match_o (dbrk_match_o[i])
        );

        // Trigger i lands in slice i
        assign cfg[i*CFG_W +: CFG_W] = trig_cfg;
        assign action_vec[i]         = trig_cfg.action;
    end

    // ------------------------------------------------
    // Requests
    // ------------------------------------------------
    // Any match raises the breakpoint exception
    assign ibrk_exc_req_o = |ibrk_match_o;
    assign dbrk_exc_req_o = |dbrk_match_o;

    // Debug entry when a retiring trigger has action 1
    assign dmode_req_o = |(action_vec & bp_retire_i);

endmodule

// ==== tests/tdu_tb_tasks.svh ====
// Testbench tasks; assume MTRIG_NUM is 2, inputs change on rising edges, outputs read at falling
// ------------------------------------------------
// Bookkeeping and random numbers
// ------------------------------------------------
task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = error_count;
endtask

task automatic finish_test();
    test_count++;
    if (error_count == test_err_base) begin
        $display("%s: ok", cur_test);
    end else begin
        $display("%s: %0d errors", cur_test, error_count - test_err_base);
    end
endtask

// Xorshift32, shifts 13/17/5
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Expected TDATA1 read word after writing w
function automatic logic [31:0] mcontrol_image(input logic [31:0] w);
    logic [31:0] img;
    img         = 32'h0;
    // Type 2, everything fixed reads zero
    img[31:28]  = 4'd2;
    img[27]     = w[27];
    img[20]     = w[20];
    // Only action value 1 is kept, as bit 12
    img[12]     = (w[17:12] == 6'd1);
    img[6]      = w[6];
    img[2:0]    = w[2:0];
    return img;
endfunction

// ------------------------------------------------
// Compare tasks
// ------------------------------------------------
task automatic compare_rsp(input string what, input tdu_csr_rsp_t exp, input tdu_csr_rsp_t act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("[ERROR] %s %s: expected rdata %h ok %b, actual rdata %h ok %b",
                 cur_test, what, exp.rdata, exp.ok, act.rdata, act.ok);
    end
endtask

task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
endtask

task automatic compare_match(input string what, input logic [MTRIG_NUM-1:0] exp,
                             input logic [MTRIG_NUM-1:0] act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("[ERROR] %s %s: expected %b actual %b", cur_test, what, exp, act);
    end
endtask

// ------------------------------------------------
// Drivers
// ------------------------------------------------
// One request cycle, write lands on the closing edge
task automatic csr_access(input tdu_csr_cmd_e cmd, input tdu_csr_addr_e addr,
                          input logic [31:0] wdata, output tdu_csr_rsp_t rsp);
    int unsigned waited;
    @(posedge clk);
    csr_req.req   <= 1'b1;
    csr_req.cmd   <= cmd;
    csr_req.addr  <= addr;
    csr_req.wdata <= wdata;
    waited = 0;
    @(negedge clk);
    while (!csr_rsp.ok && waited < RSP_TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (!csr_rsp.ok) begin
        error_count++;
        $display("%s: no CSR response within %0d cycles", cur_test, RSP_TIMEOUT);
    end
    rsp = csr_rsp;
    @(posedge clk);
    csr_req <= '0;
endtask

task automatic write_csr(input tdu_csr_cmd_e cmd, input tdu_csr_addr_e addr,
                         input logic [31:0] wdata);
    tdu_csr_rsp_t rsp;
    csr_access(cmd, addr, wdata, rsp);
endtask

task automatic expect_read(input tdu_csr_addr_e addr, input logic [31:0] exp_word,
                           input string what);
    tdu_csr_rsp_t rsp;
    tdu_csr_rsp_t exp_rsp;
    exp_rsp.rdata = exp_word;
    exp_rsp.ok    = 1'b1;
    csr_access(CSR_CMD_NONE, addr, 32'h0, rsp);
    compare_rsp(what, exp_rsp, rsp);
endtask

task automatic select_trigger(input logic [31:0] idx);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TSELECT, idx);
endtask

task automatic set_debug_mode(input logic v);
    @(posedge clk);
    dbg_mode <= v;
endtask

// Fetch strobe for one cycle, matches checked mid-cycle
task automatic probe_exec(input logic vd, input logic [31:0] addr,
                          input logic [MTRIG_NUM-1:0] exp);
    @(posedge clk);
    imon.vd   <= vd;
    imon.addr <= addr;
    @(negedge clk);
    compare_match("ibrk_match", exp, ibrk_match);
    compare_word("ibrk_exc_req", {31'b0, |exp}, {31'b0, ibrk_exc_req});
    @(posedge clk);
    imon <= '0;
endtask

task automatic probe_data(input logic vd, input logic ld, input logic st,
                          input logic [31:0] addr, input logic [MTRIG_NUM-1:0] exp);
    @(posedge clk);
    dmon.vd    <= vd;
    dmon.load  <= ld;
    dmon.store <= st;
    dmon.addr  <= addr;
    @(negedge clk);
    compare_match("dbrk_match", exp, dbrk_match);
    compare_word("dbrk_exc_req", {31'b0, |exp}, {31'b0, dbrk_exc_req});
    @(posedge clk);
    dmon <= '0;
endtask

task automatic retire_and_check(input logic [MTRIG_NUM-1:0] vec, input logic exp_dmode);
    @(posedge clk);
    bp_retire <= vec;
    @(negedge clk);
    compare_word("dmode_req", {31'b0, exp_dmode}, {31'b0, dmode_req});
    @(posedge clk);
    bp_retire <= '0;
endtask

// ------------------------------------------------
// Directed tests
// ------------------------------------------------
task automatic reset_and_tselect();
    tdu_csr_rsp_t idle_rsp;
    start_test("reset_and_tselect");
    idle_rsp = '0;
    // No request, no response
    @(negedge clk);
    compare_rsp("idle rsp", idle_rsp, csr_rsp);
    expect_read(CSR_ADDR_TSELECT, 32'h0, "tselect reset");
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0), "tdata1 reset");
    // m clear, so nothing can match
    probe_exec(1'b1, 32'h0, 2'b00);
    probe_data(1'b1, 1'b1, 1'b1, 32'h0, 2'b00);
    select_trigger(1);
    expect_read(CSR_ADDR_TSELECT, 32'h1, "tselect 1");
    select_trigger(7);
    expect_read(CSR_ADDR_TSELECT, 32'h1, "tselect 7 ignored");
    expect_read(CSR_ADDR_TINFO, 32'h4, "tinfo");
    finish_test();
endtask

task automatic tdata1_merge();
    logic [31:0] exp_word;
    logic [31:0] rnd;
    start_test("tdata1_merge");
    select_trigger(1);
    // Fixed fields set in the write data, m exec load set
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h07ec_0fdd);
    exp_word = mcontrol_image(32'h07ec_0fdd);
    expect_read(CSR_ADDR_TDATA1, exp_word, "tdata1 write");
    // Action 1 and store
    write_csr(CSR_CMD_SET, CSR_ADDR_TDATA1, 32'h0000_1002);
    exp_word = mcontrol_image(exp_word | 32'h0000_1002);
    expect_read(CSR_ADDR_TDATA1, exp_word, "tdata1 set");
    write_csr(CSR_CMD_CLEAR, CSR_ADDR_TDATA1, 32'h0000_0041);
    exp_word = mcontrol_image(exp_word & ~32'h0000_0041);
    expect_read(CSR_ADDR_TDATA1, exp_word, "tdata1 clear");
    select_trigger(0);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0), "trigger 0 untouched");
    rnd = next_rand();
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, rnd);
    expect_read(CSR_ADDR_TDATA2, rnd, "tdata2");
    finish_test();
endtask

task automatic exec_match();
    logic [31:0] addr;
    start_test("exec_match");
    addr = next_rand();
    select_trigger(1);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0);
    select_trigger(0);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_0044);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr);
    probe_exec(1'b1, addr, 2'b01);
    probe_exec(1'b1, addr ^ 32'h0000_0010, 2'b00);
    probe_exec(1'b0, addr, 2'b00);
    // Halted core never matches
    set_debug_mode(1'b1);
    probe_exec(1'b1, addr, 2'b00);
    set_debug_mode(1'b0);
    finish_test();
endtask

task automatic load_store_match();
    logic [31:0] addr;
    start_test("load_store_match");
    addr = next_rand();
    // Trigger 0 load only, trigger 1 store only, same address
    select_trigger(0);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_0041);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr);
    select_trigger(1);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_0042);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr);
    probe_data(1'b1, 1'b1, 1'b0, addr, 2'b01);
    probe_data(1'b1, 1'b0, 1'b1, addr, 2'b10);
    probe_data(1'b1, 1'b1, 1'b0, addr + 32'h4, 2'b00);
    probe_data(1'b0, 1'b1, 1'b1, addr, 2'b00);
    finish_test();
endtask

task automatic action_and_hit();
    start_test("action_and_hit");
    // Trigger 0 enters debug mode, trigger 1 raises a breakpoint
    select_trigger(0);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_1040);
    select_trigger(1);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_0040);
    retire_and_check(2'b01, 1'b1);
    retire_and_check(2'b10, 1'b0);
    retire_and_check(2'b00, 1'b0);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0010_0040), "trigger 1 hit");
    write_csr(CSR_CMD_CLEAR, CSR_ADDR_TDATA1, 32'h0010_0000);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0000_0040), "trigger 1 hit cleared");
    select_trigger(0);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0010_1040), "trigger 0 hit");
    finish_test();
endtask

task automatic dmode_lock();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    start_test("dmode_lock");
    addr_a = next_rand();
    addr_b = next_rand();
    select_trigger(0);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr_a);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0800_0040);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0800_0040), "dmode set");
    // Locked outside debug mode
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0000_0044);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr_b);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0800_0040), "tdata1 locked");
    expect_read(CSR_ADDR_TDATA2, addr_a, "tdata2 locked");
    set_debug_mode(1'b1);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA2, addr_b);
    write_csr(CSR_CMD_WRITE, CSR_ADDR_TDATA1, 32'h0800_0044);
    expect_read(CSR_ADDR_TDATA1, mcontrol_image(32'h0800_0044), "tdata1 in debug");
    expect_read(CSR_ADDR_TDATA2, addr_b, "tdata2 in debug");
    set_debug_mode(1'b0);
    finish_test();
endtask

// ==== tests/tdu_tb.sv ====
// Directed testbench for the trigger debug unit; built for two triggers, run bounded by a watchdog
`timescale 1ns/1ps

module tdu_tb;

    import tdu_pkg::*;

    localparam int unsigned MTRIG_NUM   = 2;
    // Cycles allowed for a CSR response
    localparam int unsigned RSP_TIMEOUT = 16;
    // Whole run limit in ns
    localparam int unsigned RUN_LIMIT   = 200000;

    // ------------------------------------------------
    // DUT signals
    // ------------------------------------------------
    logic                 clk;
    logic                 rst_n;
    logic                 dbg_mode;
    tdu_csr_req_t         csr_req;
    tdu_csr_rsp_t         csr_rsp;
    tdu_imon_t            imon;
    tdu_dmon_t            dmon;
    logic [MTRIG_NUM-1:0] bp_retire;
    logic [MTRIG_NUM-1:0] ibrk_match;
    logic                 ibrk_exc_req;
    logic [MTRIG_NUM-1:0] dbrk_match;
    logic                 dbrk_exc_req;
    logic                 dmode_req;

    // Bookkeeping
    string       cur_test;
    int unsigned test_count;
    int unsigned check_count;
    int unsigned error_count;
    // Error count when the current test started
    int unsigned test_err_base;
    // Xorshift state
    logic [31:0] rng_state;

    tdu_trigger_debug #(
        .MTRIG_NUM (MTRIG_NUM)
    ) i_tdu_trigger_debug (
        .clk            (clk),
        .rst_n          (rst_n),
        .dbg_mode_i     (dbg_mode),
        .csr_req_i      (csr_req),
        .csr_rsp_o      (csr_rsp),
        .imon_i         (imon),
        .ibrk_match_o   (ibrk_match),
        .ibrk_exc_req_o (ibrk_exc_req),
        .bp_retire_i    (bp_retire),
        .dmon_i         (dmon),
        .dbrk_match_o   (dbrk_match),
        .dbrk_exc_req_o (dbrk_exc_req),
        .dmode_req_o    (dmode_req)
    );

    // 4 ns period
    always #2 clk = ~clk;

    `include "tdu_tb_tasks.svh"

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        dbg_mode      = 1'b0;
        csr_req       = '0;
        imon          = '0;
        dmon          = '0;
        bp_retire     = '0;
        test_count    = 0;
        check_count   = 0;
        error_count   = 0;
        test_err_base = 0;
        rng_state     = 32'hce69;
        cur_test      = "reset";

        // Reset held for 10 cycles
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        reset_and_tselect();
        tdata1_merge();
        exec_match();
        load_store_match();
        action_and_hit();
        dmode_lock();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run limit in case a test stalls
    initial begin
        #RUN_LIMIT;
        $display("Watchdog expired during test %s, run did not complete", cur_test);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tests
verilog/tdu_pkg.sv
verilog/tdu_csr_access.sv
verilog/tdu_mcontrol_trig.sv
verilog/tdu_trigger_debug.sv
tests/tdu_tb.sv
